// File: common/core_pkg.sv
// Core datapath widths, control encodings and retire trace record
package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 1 << REG_ADDR_W;
    localparam int DMEM_BYTES  = 4096;
    localparam int DMEM_ADDR_W = $clog2(DMEM_BYTES);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA,
        OR, AND, EQ, NE, LT, GE, LTU, GEU
    } alu_op_t;

    typedef enum logic [2:0] {
        ALU, LOAD, PC4, PC_IMM, IMM
    } wb_sel_t;

    typedef enum logic [1:0] {
        SEQ, BRANCH, JAL, JALR
    } next_pc_sel_t;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      b_is_imm;
        logic      reg_we;      // Only when rd is nonzero
        wb_sel_t   wb_sel;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        logic      mem_unsigned;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      reg_we;
        reg_addr_t rd;
        word_t     wdata;
        word_t     next_pc;
    } retire_t;

endpackage

// File: common/rv_isa_pkg.sv
// RV32I instruction formats, opcode and funct3 encodings
package rv_isa_pkg;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // Branch group
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load and store group
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // ALU group, bit 30 picks sub and sra
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One fetched word, viewed in each format
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
        logic [31:0] raw;
    } instr_t;

endpackage

// File: compile.f
common/rv_isa_pkg.sv
common/core_pkg.sv
rtl/decode/control_decoder.sv
rtl/decode/imm_gen.sv
rtl/alu.sv
rtl/regfile.sv
rtl/data_mem.sv
rtl/pc_unit.sv
rtl/riscv_core.sv
testbench/tb_riscv_core.sv

// File: rtl/alu.sv
// Integer ALU with compare result for branches
`timescale 1ns/1ps

module alu (
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    input  core_pkg::alu_op_t op,
    output core_pkg::word_t   result,
    output logic              cond
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (op)
            ADD:  result = a + b;
            SUB:  result = a - b;
            SLL:  result = a << shamt;
            SLT:  result = word_t'(lt_s);
            SLTU: result = word_t'(lt_u);
            XOR:  result = a ^ b;
            SRL:  result = a >> shamt;
            SRA:  result = word_t'($signed(a) >>> shamt);
            OR:   result = a | b;
            AND:  result = a & b;
            EQ:   cond   = a == b;
            NE:   cond   = a != b;
            LT:   cond   = lt_s;
            GE:   cond   = !lt_s;
            LTU:  cond   = lt_u;
            GEU:  cond   = !lt_u;
            default: ;
        endcase
        if (op inside {EQ, NE, LT, GE, LTU, GEU})
            result = word_t'(cond);  // Compare ops also return 0 or 1
    end

endmodule

// File: rtl/data_mem.sv
// Little-endian data memory with byte lanes and load extension
`timescale 1ns/1ps

module data_mem (
    input  logic                clk,
    input  logic                reset,
    input  logic                read,
    input  logic                write,
    input  core_pkg::mem_size_t size,
    input  logic                is_unsigned,
    input  core_pkg::word_t     addr,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata
);
    import core_pkg::*;

    logic [7:0]             mem [DMEM_BYTES];
    logic [DMEM_ADDR_W-1:0] a0, a1, a2, a3;
    logic [7:0]             b0, b1, b2, b3;
    logic                   sext;

    assign a0 = addr[DMEM_ADDR_W-1:0];
    assign a1 = a0 + DMEM_ADDR_W'(1);
    assign a2 = a0 + DMEM_ADDR_W'(2);
    assign a3 = a0 + DMEM_ADDR_W'(3);

    assign b0 = mem[a0];
    assign b1 = mem[a1];
    assign b2 = mem[a2];
    assign b3 = mem[a3];

    always_ff @(posedge clk) begin
        if (write && !reset) begin
            mem[a0] <= wdata[7:0];
            if (size != BYTE)
                mem[a1] <= wdata[15:8];
            if (size == WORD) begin
                mem[a2] <= wdata[23:16];
                mem[a3] <= wdata[31:24];
            end
        end
    end

    assign sext = !is_unsigned;

    always_comb begin
        rdata = '0;
        if (read) begin
            case (size)
                BYTE:    rdata = {{24{sext & b0[7]}}, b0};
                HALF:    rdata = {{16{sext & b1[7]}}, b1, b0};
                WORD:    rdata = {b3, b2, b1, b0};
                default: rdata = '0;
            endcase
        end
    end

endmodule

// File: rtl/decode/control_decoder.sv
// Main decoder from instruction word to datapath control
`timescale 1ns/1ps

module control_decoder (
    input  rv_isa_pkg::instr_t instr,
    output core_pkg::ctrl_t    ctrl
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    function automatic alu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            F3_ADD_SUB: op = alt ? SUB : ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SRL_SRA: op = alt ? SRA : SRL;
            F3_OR:      op = OR;
            default:    op = AND;
        endcase
        return op;
    endfunction

    logic [2:0] funct3;
    logic       bit30;

    assign funct3 = instr.r.funct3;
    assign bit30  = instr.r.funct7[5];

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = ADD;
        ctrl.wb_sel   = ALU;
        ctrl.mem_size = WORD;

        case (instr.r.opcode)
            OP_LUI: begin
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = IMM;
            end
            OP_AUIPC: begin
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = PC_IMM;
            end
            OP_JAL: begin
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = PC4;
                ctrl.is_jal = 1'b1;
            end
            OP_JALR: begin
                ctrl.reg_we   = 1'b1;
                ctrl.wb_sel   = PC4;
                ctrl.b_is_imm = 1'b1;
                ctrl.is_jalr  = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                case (funct3)
                    F3_BEQ:  ctrl.alu_op = EQ;
                    F3_BNE:  ctrl.alu_op = NE;
                    F3_BLT:  ctrl.alu_op = LT;
                    F3_BGE:  ctrl.alu_op = GE;
                    F3_BLTU: ctrl.alu_op = LTU;
                    F3_BGEU: ctrl.alu_op = GEU;
                    default: ctrl.is_branch = 1'b0;  // Reserved encodings fall through
                endcase
            end
            OP_LOAD: begin
                ctrl.reg_we   = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.wb_sel   = LOAD;
                ctrl.b_is_imm = 1'b1;
                case (funct3)
                    F3_LB:   ctrl.mem_size = BYTE;
                    F3_LH:   ctrl.mem_size = HALF;
                    F3_LBU:  ctrl.mem_size = BYTE;
                    F3_LHU:  ctrl.mem_size = HALF;
                    default: ctrl.mem_size = WORD;
                endcase
                ctrl.mem_unsigned = (funct3 == F3_LBU) || (funct3 == F3_LHU);
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                case (funct3)
                    F3_SB:   ctrl.mem_size = BYTE;
                    F3_SH:   ctrl.mem_size = HALF;
                    F3_SW:   ctrl.mem_size = WORD;
                    default: ctrl.mem_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                ctrl.reg_we   = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = alu_op_of(funct3, bit30 && (funct3 == F3_SRL_SRA));
            end
            OP_REG: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_op_of(funct3, bit30);
            end
            default: ;  // Unknown opcode retires as a no-op
        endcase

        if (instr.r.rd == '0)
            ctrl.reg_we = 1'b0;
    end

endmodule

// File: rtl/decode/imm_gen.sv
// Sign-extended immediate extraction for all RV32I formats
`timescale 1ns/1ps

module imm_gen (
    input  rv_isa_pkg::instr_t instr,
    output core_pkg::word_t    imm
);
    import rv_isa_pkg::*;

    always_comb begin
        case (instr.r.opcode)
            OP_IMM, OP_LOAD, OP_JALR:
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            OP_STORE:
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            OP_BRANCH:
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {instr.u.imm, 12'b0};  // Upper twenty bits
            OP_JAL:
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default:
                imm = '0;  // R-type has none
        endcase
    end

endmodule

// File: rtl/pc_unit.sv
// Program counter and next-PC selection
`timescale 1ns/1ps

module pc_unit (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::ctrl_t ctrl,
    input  logic            cond,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t imm,
    output core_pkg::word_t pc,
    output core_pkg::word_t next_pc
);
    import core_pkg::*;

    next_pc_sel_t sel;
    word_t        jalr_sum;

    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if (ctrl.is_jalr)
            sel = JALR;
        else if (ctrl.is_jal)
            sel = JAL;
        else if (ctrl.is_branch && cond)
            sel = BRANCH;  // Taken branch only
        else
            sel = SEQ;
    end

    always_comb begin
        case (sel)
            BRANCH, JAL: next_pc = pc + imm;
            JALR:        next_pc = {jalr_sum[XLEN-1:1], 1'b0};
            default:     next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= '0;
        else
            pc <= next_pc;
    end

endmodule

// File: rtl/regfile.sv
// Integer register file, two read ports and one write port
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);
    import core_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < NUM_REGS; k++)
                regs[k] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 always reads zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rtl/riscv_core.sv
// Single-cycle RV32I core top with retire trace
`timescale 1ns/1ps

module riscv_core (
    input  logic              clk,
    input  logic              reset,
    output core_pkg::word_t   imem_addr,
    input  core_pkg::word_t   imem_data,
    output core_pkg::retire_t trace
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    instr_t instr;
    ctrl_t  ctrl;
    word_t  imm;
    word_t  rs1_data, rs2_data;
    word_t  alu_b, alu_result;
    word_t  load_data;
    word_t  pc, next_pc;
    word_t  wb_data;
    logic   cond;
    logic   reg_we;

    assign instr     = instr_t'(imem_data);
    assign imem_addr = pc;
    assign alu_b     = ctrl.b_is_imm ? imm : rs2_data;
    assign reg_we    = ctrl.reg_we && !reset;

    control_decoder control_decoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    imm_gen imm_gen_i (
        .instr (instr),
        .imm   (imm)
    );

    regfile regfile_i (
        .clk      (clk),
        .reset    (reset),
        .we       (reg_we),
        .rs1      (instr.r.rs1),
        .rs2      (instr.r.rs2),
        .rd       (instr.r.rd),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu alu_i (
        .a      (rs1_data),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .cond   (cond)
    );

    data_mem data_mem_i (
        .clk         (clk),
        .reset       (reset),
        .read        (ctrl.mem_read),
        .write       (ctrl.mem_write),
        .size        (ctrl.mem_size),
        .is_unsigned (ctrl.mem_unsigned),
        .addr        (alu_result),  // Base plus offset
        .wdata       (rs2_data),
        .rdata       (load_data)
    );

    pc_unit pc_unit_i (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .cond     (cond),
        .rs1_data (rs1_data),
        .imm      (imm),
        .pc       (pc),
        .next_pc  (next_pc)
    );

    always_comb begin
        case (ctrl.wb_sel)
            ALU:     wb_data = alu_result;
            LOAD:    wb_data = load_data;
            PC4:     wb_data = pc + 32'd4;  // Link address
            PC_IMM:  wb_data = pc + imm;
            IMM:     wb_data = imm;
            default: wb_data = '0;
        endcase
    end

    always_comb begin
        trace.valid   = !reset;
        trace.pc      = pc;
        trace.reg_we  = reg_we;
        trace.rd      = instr.r.rd;
        trace.wdata   = wb_data;
        trace.next_pc = next_pc;
    end

endmodule

// File: testbench/tb_riscv_core.sv
// Testbench for the single-cycle RV32I core driven from program and retire tables
`timescale 1ns/1ps

module tb_riscv_core;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int         CLK_PERIOD   = 100;
    localparam int         RESET_CYCLES = 5;
    localparam int         PROG_WORDS   = 256;
    localparam logic [6:0] F7_ALT       = 7'b0100000;

    logic    clk;
    logic    reset;
    word_t   imem_addr;
    word_t   imem_data;
    retire_t trace;

    word_t   prog [PROG_WORDS];
    word_t   xr [32];              // Expected register contents
    retire_t exp_q [$];
    word_t   cur_pc;
    integer  seed;
    logic    table_ready = 1'b0;

    riscv_core riscv_core_i (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .trace     (trace)
    );

    assign imem_data = prog[imem_addr[9:2]];  // Word-indexed fetch

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t store_word(input logic [2:0] f3, input logic [4:0] src,
                                         input logic [4:0] base, input logic [11:0] imm);
        return {imm[11:5], src, base, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [6:0] op, input logic [4:0] rd,
                                     input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic word_t jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Places one instruction at the current PC and queues its retire record
    task automatic add_row(input word_t instr, input logic we, input logic [4:0] rd,
                           input word_t wdata, input word_t npc);
        retire_t row;
        row.valid   = 1'b1;
        row.pc      = cur_pc;
        row.reg_we  = we;
        row.rd      = rd;
        row.wdata   = wdata;
        row.next_pc = npc;
        prog[cur_pc[9:2]] = instr;
        exp_q.push_back(row);
        if (we)
            xr[rd] = wdata;
        cur_pc = npc;
    endtask

    task automatic alu_row(input word_t instr, input logic [4:0] rd, input word_t value);
        add_row(instr, rd != 5'd0, rd, value, cur_pc + 32'd4);
    endtask

    task automatic store_row(input word_t instr);
        add_row(instr, 1'b0, 5'd0, '0, cur_pc + 32'd4);
    endtask

    task automatic branch_row(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic taken);
        add_row(branch_word(f3, rs1, rs2, 13'd8), 1'b0, 5'd0, '0,
                taken ? cur_pc + 32'd8 : cur_pc + 32'd4);
    endtask

    task automatic build_tables();
        word_t       rnd;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        word_t       target;
        for (int k = 0; k < PROG_WORDS; k++)
            prog[k] = i_type(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, k[11:0]);  // Unique no-ops
        for (int k = 0; k < 32; k++)
            xr[k] = '0;
        cur_pc = '0;
        rnd    = $random(seed);
        imm_a  = rnd[11:0];
        rnd    = $random(seed);
        imm_b  = rnd[11:0];

        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd1, 5'd0, imm_a), 5'd1, sext12(imm_a));
        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd2, 5'd0, imm_b), 5'd2, sext12(imm_b));
        alu_row(u_type(OP_LUI, 5'd3, 20'h12345), 5'd3, 32'h1234_5000);
        alu_row(u_type(OP_LUI, 5'd10, 20'hF0F0F), 5'd10, 32'hF0F0_F000);
        alu_row(u_type(OP_AUIPC, 5'd4, 20'h00010), 5'd4, cur_pc + 32'h0001_0000);
        alu_row(r_type(7'd0, F3_ADD_SUB, 5'd5, 5'd1, 5'd2), 5'd5, xr[1] + xr[2]);
        alu_row(r_type(F7_ALT, F3_ADD_SUB, 5'd6, 5'd1, 5'd2), 5'd6, xr[1] - xr[2]);
        alu_row(r_type(7'd0, F3_SLL, 5'd7, 5'd3, 5'd1), 5'd7, xr[3] << xr[1][4:0]);
        alu_row(r_type(7'd0, F3_SRL_SRA, 5'd8, 5'd10, 5'd2), 5'd8, xr[10] >> xr[2][4:0]);
        alu_row(r_type(F7_ALT, F3_SRL_SRA, 5'd9, 5'd10, 5'd2), 5'd9,
                $signed(xr[10]) >>> xr[2][4:0]);
        alu_row(r_type(7'd0, F3_SLT, 5'd11, 5'd1, 5'd2), 5'd11,
                {31'd0, $signed(xr[1]) < $signed(xr[2])});
        alu_row(r_type(7'd0, F3_SLTU, 5'd12, 5'd1, 5'd2), 5'd12, {31'd0, xr[1] < xr[2]});
        alu_row(r_type(7'd0, F3_XOR, 5'd13, 5'd1, 5'd2), 5'd13, xr[1] ^ xr[2]);
        alu_row(r_type(7'd0, F3_OR, 5'd14, 5'd1, 5'd2), 5'd14, xr[1] | xr[2]);
        alu_row(r_type(7'd0, F3_AND, 5'd15, 5'd1, 5'd2), 5'd15, xr[1] & xr[2]);
        alu_row(r_type(7'd0, F3_ADD_SUB, 5'd0, 5'd1, 5'd2), 5'd0, xr[1] + xr[2]);
        alu_row(r_type(7'd0, F3_ADD_SUB, 5'd16, 5'd0, 5'd1), 5'd16, xr[0] + xr[1]);

        // Word 0x8765F4A9 at 0x100 as bytes A9 F4 65 87
        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd20, 5'd0, 12'h100), 5'd20, 32'h0000_0100);
        alu_row(u_type(OP_LUI, 5'd21, 20'h8765F), 5'd21, 32'h8765_F000);
        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd21, 5'd21, 12'h4A9), 5'd21, xr[21] + 32'h4A9);
        store_row(store_word(F3_SW, 5'd21, 5'd20, 12'd0));
        store_row(store_word(F3_SH, 5'd21, 5'd20, 12'd6));
        store_row(store_word(F3_SB, 5'd21, 5'd20, 12'd9));
        alu_row(i_type(OP_LOAD, F3_LW, 5'd22, 5'd20, 12'd0), 5'd22, 32'h8765_F4A9);
        alu_row(i_type(OP_LOAD, F3_LH, 5'd23, 5'd20, 12'd0), 5'd23, 32'hFFFF_F4A9);
        alu_row(i_type(OP_LOAD, F3_LHU, 5'd24, 5'd20, 12'd0), 5'd24, 32'h0000_F4A9);
        alu_row(i_type(OP_LOAD, F3_LH, 5'd25, 5'd20, 12'd2), 5'd25, 32'hFFFF_8765);
        alu_row(i_type(OP_LOAD, F3_LHU, 5'd26, 5'd20, 12'd6), 5'd26, 32'h0000_F4A9);
        alu_row(i_type(OP_LOAD, F3_LB, 5'd27, 5'd20, 12'd9), 5'd27, 32'hFFFF_FFA9);
        alu_row(i_type(OP_LOAD, F3_LBU, 5'd28, 5'd20, 12'd0), 5'd28, 32'h0000_00A9);
        alu_row(i_type(OP_LOAD, F3_LB, 5'd29, 5'd20, 12'd2), 5'd29, 32'h0000_0065);

        // x30 = -5, x31 = 7
        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd30, 5'd0, 12'hFFB), 5'd30, 32'hFFFF_FFFB);
        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd31, 5'd0, 12'd7), 5'd31, 32'd7);
        branch_row(F3_BEQ, 5'd31, 5'd31, xr[31] == xr[31]);
        branch_row(F3_BEQ, 5'd30, 5'd31, xr[30] == xr[31]);
        branch_row(F3_BNE, 5'd30, 5'd31, xr[30] != xr[31]);
        branch_row(F3_BNE, 5'd31, 5'd31, xr[31] != xr[31]);
        branch_row(F3_BLT, 5'd30, 5'd31, $signed(xr[30]) < $signed(xr[31]));
        branch_row(F3_BLT, 5'd31, 5'd30, $signed(xr[31]) < $signed(xr[30]));
        branch_row(F3_BGE, 5'd31, 5'd30, $signed(xr[31]) >= $signed(xr[30]));
        branch_row(F3_BGE, 5'd30, 5'd31, $signed(xr[30]) >= $signed(xr[31]));
        branch_row(F3_BLTU, 5'd31, 5'd30, xr[31] < xr[30]);
        branch_row(F3_BLTU, 5'd30, 5'd31, xr[30] < xr[31]);
        branch_row(F3_BGEU, 5'd30, 5'd31, xr[30] >= xr[31]);
        branch_row(F3_BGEU, 5'd31, 5'd30, xr[31] >= xr[30]);

        add_row(jal_word(5'd1, 21'd12), 1'b1, 5'd1, cur_pc + 32'd4, cur_pc + 32'd12);
        target = cur_pc + 32'd16;
        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd19, 5'd0, target[11:0]), 5'd19, target);
        add_row(i_type(OP_JALR, 3'b000, 5'd7, 5'd19, 12'd1), 1'b1, 5'd7,
                cur_pc + 32'd4, (xr[19] + 32'd1) & ~32'd1);  // Odd sum with bit 0 dropped
        alu_row(i_type(OP_IMM, F3_ADD_SUB, 5'd8, 5'd7, 12'd0), 5'd8, xr[7]);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_row(input retire_t row);
        check_value("imem_addr", imem_addr, row.pc);
        check_value("trace.valid", trace.valid, 1'b1);
        check_value("trace.pc", trace.pc, row.pc);
        check_value("trace.reg_we", trace.reg_we, row.reg_we);
        if (row.reg_we) begin
            check_value("trace.rd", trace.rd, row.rd);
            check_value("trace.wdata", trace.wdata, row.wdata);
        end
        check_value("trace.next_pc", trace.next_pc, row.next_pc);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = exp_q.size() + RESET_CYCLES + 20;
        #(limit * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("TESTS FAILED");
        $fatal(1);
    end

    // Trace sampled mid-cycle at the falling edge
    initial begin
        seed = 57534;
        build_tables();
        table_ready = 1'b1;
        @(negedge clk);
        while (reset) begin
            check_value("trace.valid", trace.valid, 1'b0);
            check_value("trace.reg_we", trace.reg_we, 1'b0);
            @(negedge clk);
        end
        foreach (exp_q[i]) begin
            check_row(exp_q[i]);
            @(negedge clk);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule
